/* ext_mem_consts.svh */
`ifndef EXT_MEM_CONSTS_SVH
`define EXT_MEM_CONSTS_SVH

// Byte address width of every bus in the subsystem
`define EXT_MEM_ADDR_W 14

// One word per line, one word per bus beat
`define EXT_MEM_DATA_W 32

// First-level caches, 16 lines each
`define EXT_MEM_L1_IDX_W 4

// Shared second-level cache, 64 lines
`define EXT_MEM_L2_IDX_W 6

// Data-cache control register, last word of the address space
// A write here flushes the data cache and the second level
`define EXT_MEM_CTRL_ADDR 14'h3FFC

`endif

/* ext_mem_pkg.sv */
`default_nettype none

`include "ext_mem_consts.svh"

package ext_mem_pkg;

   typedef logic [`EXT_MEM_ADDR_W-1:0]   addr_t;   // Byte address
   typedef logic [`EXT_MEM_DATA_W-1:0]   data_t;
   typedef logic [`EXT_MEM_DATA_W/8-1:0] strb_t;   // All zero is a read

   // Cache controller states
   typedef enum logic [2:0] {
      IDLE,     // Accepting requests
      LOOKUP,   // Tag compare or control access
      FETCH,    // Line fill from back-end
      WRITE,    // Write-through to back-end
      RESPOND   // Read data out
   } cache_state_t;

endpackage

`default_nettype wire

/* line_cache.sv */
`default_nettype none

`include "ext_mem_consts.svh"

module line_cache #(
   parameter int IDX_W    = `EXT_MEM_L1_IDX_W,
   parameter bit USE_CTRL = 1'b0
) (
   input  wire                 clk_i,
   input  wire                 arst_i,
   // Front-end
   input  wire                 fe_valid_i,
   input  wire ext_mem_pkg::addr_t fe_addr_i,
   input  wire ext_mem_pkg::data_t fe_wdata_i,
   input  wire ext_mem_pkg::strb_t fe_wstrb_i,
   output logic                fe_ready_o,
   output ext_mem_pkg::data_t  fe_rdata_o,
   output logic                fe_rvalid_o,
   // Back-end
   output logic                be_valid_o,
   output ext_mem_pkg::addr_t  be_addr_o,
   output ext_mem_pkg::data_t  be_wdata_o,
   output ext_mem_pkg::strb_t  be_wstrb_o,
   input  wire                 be_ready_i,
   input  wire ext_mem_pkg::data_t be_rdata_i,
   input  wire                 be_rvalid_i,
   // Flush control
   input  wire                 invalidate_i,
   output logic                invalidate_o
);

   localparam int LINES = 1 << IDX_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - 2 - IDX_W;   // Word-aligned lines
   localparam int NBYTES = $bits(ext_mem_pkg::strb_t);

   ext_mem_pkg::cache_state_t state_q;

   // Captured request
   ext_mem_pkg::addr_t req_addr_q;
   ext_mem_pkg::data_t req_wdata_q;
   ext_mem_pkg::strb_t req_wstrb_q;
   logic               req_ctrl_q;     // Control register write
   logic               fetch_sent_q;   // Fill read accepted downstream
   ext_mem_pkg::data_t rdata_q;

   logic [TAG_W-1:0]   tag_mem  [LINES];
   ext_mem_pkg::data_t data_mem [LINES];
   logic [LINES-1:0]   valid_q;

   logic [IDX_W-1:0] req_idx;
   logic [TAG_W-1:0] req_tag;
   logic             hit;
   logic             fe_write;
   logic             fe_ctrl;
   logic             fill;
   logic             wr_done;

   assign req_idx = req_addr_q[IDX_W+1:2];
   assign req_tag = req_addr_q[`EXT_MEM_ADDR_W-1:IDX_W+2];
   assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

   assign fe_write = |fe_wstrb_i;
   assign fe_ctrl  = USE_CTRL && fe_write && (fe_addr_i == `EXT_MEM_CTRL_ADDR);

   assign fill    = (state_q == ext_mem_pkg::FETCH) && fetch_sent_q && be_rvalid_i;
   assign wr_done = (state_q == ext_mem_pkg::WRITE) && be_ready_i;

   assign fe_ready_o   = fe_valid_i && (state_q == ext_mem_pkg::IDLE);
   assign fe_rvalid_o  = (state_q == ext_mem_pkg::RESPOND);
   assign fe_rdata_o   = rdata_q;
   assign invalidate_o = (state_q == ext_mem_pkg::LOOKUP) && req_ctrl_q;

   // Read fill or write-through, never both
   assign be_valid_o = (state_q == ext_mem_pkg::WRITE) ||
                       ((state_q == ext_mem_pkg::FETCH) && !fetch_sent_q);
   assign be_addr_o  = req_addr_q;
   assign be_wdata_o = req_wdata_q;
   assign be_wstrb_o = (state_q == ext_mem_pkg::WRITE) ? req_wstrb_q : '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q      <= ext_mem_pkg::IDLE;
         req_ctrl_q   <= 1'b0;
         fetch_sent_q <= 1'b0;
      end else begin
         case (state_q)
            ext_mem_pkg::IDLE: begin
               if (fe_ready_o) begin
                  req_ctrl_q <= fe_ctrl;
                  if (fe_write && !fe_ctrl) begin
                     state_q <= ext_mem_pkg::WRITE;
                  end else begin
                     state_q <= ext_mem_pkg::LOOKUP;
                  end
               end
            end
            ext_mem_pkg::LOOKUP: begin
               if (req_ctrl_q) begin
                  state_q <= ext_mem_pkg::IDLE;   // Flush done this cycle
               end else if (hit) begin
                  state_q <= ext_mem_pkg::RESPOND;
               end else begin
                  state_q <= ext_mem_pkg::FETCH;
               end
            end
            ext_mem_pkg::FETCH: begin
               if (be_valid_o && be_ready_i) fetch_sent_q <= 1'b1;
               if (fill) begin
                  fetch_sent_q <= 1'b0;
                  state_q      <= ext_mem_pkg::RESPOND;
               end
            end
            ext_mem_pkg::WRITE: begin
               if (wr_done) state_q <= ext_mem_pkg::IDLE;
            end
            default: state_q <= ext_mem_pkg::IDLE;   // RESPOND lasts one cycle
         endcase
      end
   end

   // Line valid bits, a fill after a flush still lands
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else begin
         if (invalidate_i || invalidate_o) valid_q <= '0;
         if (fill) valid_q[req_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fe_ready_o) begin
         req_addr_q  <= fe_addr_i;
         req_wdata_q <= fe_wdata_i;
         req_wstrb_q <= fe_wstrb_i;
      end
      if ((state_q == ext_mem_pkg::LOOKUP) && hit && !req_ctrl_q) begin
         rdata_q <= data_mem[req_idx];
      end
      if (fill) begin
         rdata_q           <= be_rdata_i;
         data_mem[req_idx] <= be_rdata_i;
         tag_mem[req_idx]  <= req_tag;
      end
      // Write hit keeps the cached word in step with memory
      if (wr_done && hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (req_wstrb_q[b]) data_mem[req_idx][8*b +: 8] <= req_wdata_q[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

/* bus_merge.sv */
`default_nettype none

module bus_merge (
   input  wire                     clk_i,
   input  wire                     arst_i,
   // Master 0, instruction side
   input  wire                     m0_valid_i,
   input  wire ext_mem_pkg::addr_t m0_addr_i,
   input  wire ext_mem_pkg::data_t m0_wdata_i,
   input  wire ext_mem_pkg::strb_t m0_wstrb_i,
   output logic                    m0_ready_o,
   output ext_mem_pkg::data_t      m0_rdata_o,
   output logic                    m0_rvalid_o,
   // Master 1, data side
   input  wire                     m1_valid_i,
   input  wire ext_mem_pkg::addr_t m1_addr_i,
   input  wire ext_mem_pkg::data_t m1_wdata_i,
   input  wire ext_mem_pkg::strb_t m1_wstrb_i,
   output logic                    m1_ready_o,
   output ext_mem_pkg::data_t      m1_rdata_o,
   output logic                    m1_rvalid_o,
   // Slave
   output logic                    s_valid_o,
   output ext_mem_pkg::addr_t      s_addr_o,
   output ext_mem_pkg::data_t      s_wdata_o,
   output ext_mem_pkg::strb_t      s_wstrb_o,
   input  wire                     s_ready_i,
   input  wire ext_mem_pkg::data_t s_rdata_i,
   input  wire                     s_rvalid_i
);

   logic lock_q;    // Read outstanding on the slave
   logic owner_q;   // Master that issued it
   logic sel;       // 1 selects master 1

   // Data side wins unless a read is still in flight
   assign sel = lock_q ? owner_q : m1_valid_i;

   assign s_valid_o = sel ? m1_valid_i : m0_valid_i;
   assign s_addr_o  = sel ? m1_addr_i  : m0_addr_i;
   assign s_wdata_o = sel ? m1_wdata_i : m0_wdata_i;
   assign s_wstrb_o = sel ? m1_wstrb_i : m0_wstrb_i;

   assign m0_ready_o = !sel && s_ready_i;
   assign m1_ready_o = sel && s_ready_i;

   assign m0_rdata_o  = s_rdata_i;
   assign m1_rdata_o  = s_rdata_i;
   assign m0_rvalid_o = s_rvalid_i && !owner_q;
   assign m1_rvalid_o = s_rvalid_i && owner_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lock_q  <= 1'b0;
         owner_q <= 1'b0;
      end else begin
         if (s_rvalid_i) lock_q <= 1'b0;
         // Only reads hold the grant
         if (s_valid_o && s_ready_i && (s_wstrb_o == '0)) begin
            lock_q  <= 1'b1;
            owner_q <= sel;
         end
      end
   end

endmodule

`default_nettype wire

/* ext_mem.sv */
`default_nettype none

`include "ext_mem_consts.svh"

module ext_mem (
   input  wire                     clk_i,
   input  wire                     arst_i,
   // Instruction front-end, read only
   input  wire                     i_valid_i,
   input  wire ext_mem_pkg::addr_t i_addr_i,
   output logic                    i_ready_o,
   output ext_mem_pkg::data_t      i_rdata_o,
   output logic                    i_rvalid_o,
   // Data front-end
   input  wire                     d_valid_i,
   input  wire ext_mem_pkg::addr_t d_addr_i,
   input  wire ext_mem_pkg::data_t d_wdata_i,
   input  wire ext_mem_pkg::strb_t d_wstrb_i,
   output logic                    d_ready_o,
   output ext_mem_pkg::data_t      d_rdata_o,
   output logic                    d_rvalid_o,
   // External memory
   output logic                    mem_valid_o,
   output ext_mem_pkg::addr_t      mem_addr_o,
   output ext_mem_pkg::data_t      mem_wdata_o,
   output ext_mem_pkg::strb_t      mem_wstrb_o,
   input  wire                     mem_ready_i,
   input  wire ext_mem_pkg::data_t mem_rdata_i,
   input  wire                     mem_rvalid_i
);

   logic ic_be_valid, ic_be_ready, ic_be_rvalid;
   ext_mem_pkg::addr_t ic_be_addr;
   ext_mem_pkg::data_t ic_be_wdata, ic_be_rdata;
   ext_mem_pkg::strb_t ic_be_wstrb;

   logic dc_be_valid, dc_be_ready, dc_be_rvalid;
   ext_mem_pkg::addr_t dc_be_addr;
   ext_mem_pkg::data_t dc_be_wdata, dc_be_rdata;
   ext_mem_pkg::strb_t dc_be_wstrb;

   logic l2_valid, l2_ready, l2_rvalid;
   ext_mem_pkg::addr_t l2_addr;
   ext_mem_pkg::data_t l2_wdata, l2_rdata;
   ext_mem_pkg::strb_t l2_wstrb;

   logic dc_inval;     // Control register write seen by dcache
   logic inval_hold;   // Pending second-level flush

   line_cache #(.IDX_W(`EXT_MEM_L1_IDX_W), .USE_CTRL(1'b0)) icache (
      .clk_i, .arst_i,
      .fe_valid_i(i_valid_i), .fe_addr_i(i_addr_i),
      .fe_wdata_i('0), .fe_wstrb_i('0),   // Fetch only
      .fe_ready_o(i_ready_o), .fe_rdata_o(i_rdata_o), .fe_rvalid_o(i_rvalid_o),
      .be_valid_o(ic_be_valid), .be_addr_o(ic_be_addr),
      .be_wdata_o(ic_be_wdata), .be_wstrb_o(ic_be_wstrb),
      .be_ready_i(ic_be_ready), .be_rdata_i(ic_be_rdata), .be_rvalid_i(ic_be_rvalid),
      .invalidate_i(1'b0), .invalidate_o()
   );

   line_cache #(.IDX_W(`EXT_MEM_L1_IDX_W), .USE_CTRL(1'b1)) dcache (
      .clk_i, .arst_i,
      .fe_valid_i(d_valid_i), .fe_addr_i(d_addr_i),
      .fe_wdata_i(d_wdata_i), .fe_wstrb_i(d_wstrb_i),
      .fe_ready_o(d_ready_o), .fe_rdata_o(d_rdata_o), .fe_rvalid_o(d_rvalid_o),
      .be_valid_o(dc_be_valid), .be_addr_o(dc_be_addr),
      .be_wdata_o(dc_be_wdata), .be_wstrb_o(dc_be_wstrb),
      .be_ready_i(dc_be_ready), .be_rdata_i(dc_be_rdata), .be_rvalid_i(dc_be_rvalid),
      .invalidate_i(1'b0), .invalidate_o(dc_inval)
   );

   bus_merge merge_i_d (
      .clk_i, .arst_i,
      .m0_valid_i(ic_be_valid), .m0_addr_i(ic_be_addr),
      .m0_wdata_i(ic_be_wdata), .m0_wstrb_i(ic_be_wstrb),
      .m0_ready_o(ic_be_ready), .m0_rdata_o(ic_be_rdata), .m0_rvalid_o(ic_be_rvalid),
      .m1_valid_i(dc_be_valid), .m1_addr_i(dc_be_addr),
      .m1_wdata_i(dc_be_wdata), .m1_wstrb_i(dc_be_wstrb),
      .m1_ready_o(dc_be_ready), .m1_rdata_o(dc_be_rdata), .m1_rvalid_o(dc_be_rvalid),
      .s_valid_o(l2_valid), .s_addr_o(l2_addr), .s_wdata_o(l2_wdata), .s_wstrb_o(l2_wstrb),
      .s_ready_i(l2_ready), .s_rdata_i(l2_rdata), .s_rvalid_i(l2_rvalid)
   );

   // Keep the flush request until the second level sees no request
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) inval_hold <= 1'b0;
      else if (dc_inval) inval_hold <= 1'b1;
      else if (!l2_valid) inval_hold <= 1'b0;
   end

   line_cache #(.IDX_W(`EXT_MEM_L2_IDX_W), .USE_CTRL(1'b0)) l2cache (
      .clk_i, .arst_i,
      .fe_valid_i(l2_valid), .fe_addr_i(l2_addr),
      .fe_wdata_i(l2_wdata), .fe_wstrb_i(l2_wstrb),
      .fe_ready_o(l2_ready), .fe_rdata_o(l2_rdata), .fe_rvalid_o(l2_rvalid),
      .be_valid_o(mem_valid_o), .be_addr_o(mem_addr_o),
      .be_wdata_o(mem_wdata_o), .be_wstrb_o(mem_wstrb_o),
      .be_ready_i(mem_ready_i), .be_rdata_i(mem_rdata_i), .be_rvalid_i(mem_rvalid_i),
      .invalidate_i(inval_hold && !l2_valid), .invalidate_o()
   );

endmodule

`default_nettype wire

/* tb_ext_mem.sv */
`default_nettype none

`include "ext_mem_consts.svh"

module tb_ext_mem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_TRANS    = 325;   // Reads and writes over all tests
   localparam int MAX_CYCLES = 64 * N_TRANS;
   localparam int MEM_WORDS  = 4096;

   logic clk_i;
   logic arst_i;
   logic i_valid_i, i_ready_o, i_rvalid_o;
   ext_mem_pkg::addr_t i_addr_i;
   ext_mem_pkg::data_t i_rdata_o;
   logic d_valid_i, d_ready_o, d_rvalid_o;
   ext_mem_pkg::addr_t d_addr_i;
   ext_mem_pkg::data_t d_wdata_i, d_rdata_o;
   ext_mem_pkg::strb_t d_wstrb_i;
   logic mem_valid_o, mem_ready_i, mem_rvalid_i;
   ext_mem_pkg::addr_t mem_addr_o;
   ext_mem_pkg::data_t mem_wdata_o, mem_rdata_i;
   ext_mem_pkg::strb_t mem_wstrb_o;

   ext_mem_pkg::data_t mem     [MEM_WORDS];   // Storage behind the memory port
   ext_mem_pkg::data_t ref_mem [MEM_WORDS];   // Expected contents
   ext_mem_pkg::data_t i_exp, d_exp;
   logic  hit_expected;
   string test_name;
   int    errors = 0;
   int    tests = 0;
   int    cycles = 0;
   int    mem_reads = 0;
   int    mem_writes = 0;

   ext_mem UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Preload pattern unique to every word address
   function automatic ext_mem_pkg::data_t fill_word(input int w);
      return {4'hC, w[11:0], 4'h3, ~w[11:0]};
   endfunction

   function automatic ext_mem_pkg::data_t merge_bytes(input ext_mem_pkg::data_t old_w,
         input ext_mem_pkg::data_t new_w, input ext_mem_pkg::strb_t st);
      ext_mem_pkg::data_t r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (st[b]) r[8*b +: 8] = new_w[8*b +: 8];
      end
      return r;
   endfunction

   // Memory with random accept delay and read latency
   initial begin : mem_model
      int          ready_wait;
      int          rd_wait;
      logic [11:0] rd_word;
      ready_wait   = -1;
      rd_wait      = 0;
      rd_word      = '0;
      mem_ready_i  = 1'b0;
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      forever begin
         @(posedge clk_i);
         #1;
         mem_ready_i  = 1'b0;
         mem_rvalid_i = 1'b0;
         if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
               mem_rvalid_i = 1'b1;
               mem_rdata_i  = mem[rd_word];
            end
         end
         if (mem_valid_o && !arst_i) begin
            if (ready_wait < 0) ready_wait = int'($urandom_range(0, 3));
            if (ready_wait == 0) begin
               mem_ready_i = 1'b1;   // Request is held, so it lands on the next edge
               ready_wait  = -1;
               if (mem_wstrb_o == '0) begin
                  rd_word = mem_addr_o[13:2];
                  rd_wait = int'($urandom_range(1, 4));
                  mem_reads++;
               end else begin
                  mem[mem_addr_o[13:2]] = merge_bytes(mem[mem_addr_o[13:2]], mem_wdata_o,
                                                      mem_wstrb_o);
                  mem_writes++;
               end
            end else begin
               ready_wait--;
            end
         end
      end
   end

   // Outputs settle after the rising edge, so check on the falling one
   i_data_check: assert property (@(negedge clk_i) disable iff (arst_i)
      i_rvalid_o |-> (i_rdata_o == i_exp))
      else begin
         errors++;
         $display("** Error %s: i_rdata expected %h, actual %h", test_name, i_exp, i_rdata_o);
      end

   d_data_check: assert property (@(negedge clk_i) disable iff (arst_i)
      d_rvalid_o |-> (d_rdata_o == d_exp))
      else begin
         errors++;
         $display("** Error %s: d_rdata expected %h, actual %h", test_name, d_exp, d_rdata_o);
      end

   reset_quiet: assert property (@(negedge clk_i)
      arst_i |-> !(mem_valid_o || i_ready_o || d_ready_o || i_rvalid_o || d_rvalid_o))
      else begin
         errors++;
         $display("%s: a valid, ready or rvalid output was high during reset", test_name);
      end

   hit_no_fetch: assert property (@(negedge clk_i) disable iff (arst_i)
      hit_expected |-> !(mem_valid_o && (mem_wstrb_o == '0)))
      else begin
         errors++;
         $display("%s: memory read issued where a cache hit was expected", test_name);
      end

   task automatic instr_read(input ext_mem_pkg::addr_t a, input ext_mem_pkg::data_t exp);
      i_exp     = exp;
      i_valid_i = 1'b1;
      i_addr_i  = a;
      @(negedge clk_i);
      while (!i_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      i_valid_i = 1'b0;
      @(negedge clk_i);
      while (!i_rvalid_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
   endtask

   // Zero strobe is a read checked against exp and any other strobe is a write
   task automatic data_req(input ext_mem_pkg::addr_t a, input ext_mem_pkg::data_t wd,
         input ext_mem_pkg::strb_t st, input ext_mem_pkg::data_t exp);
      d_exp     = exp;
      d_valid_i = 1'b1;
      d_addr_i  = a;
      d_wdata_i = wd;
      d_wstrb_i = st;
      if ((st != '0) && (a != `EXT_MEM_CTRL_ADDR)) begin
         ref_mem[a[13:2]] = merge_bytes(ref_mem[a[13:2]], wd, st);
      end
      @(negedge clk_i);
      while (!d_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      d_valid_i = 1'b0;
      if (st == '0) begin
         @(negedge clk_i);
         while (!d_rvalid_o) @(negedge clk_i);
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic end_test(input int err_before);
      tests++;
      $display("Test %0d %s %s", tests, test_name, (errors == err_before) ? "ok" : "errors");
   endtask

   initial begin : watchdog
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout after %0d cycles, a request never completed", cycles);
      $display("TB FAILED");
      $finish;
   end

   initial begin : stimulus
      logic [11:0]        dw, iw;
      logic               wr;
      ext_mem_pkg::data_t wd, old_w;
      ext_mem_pkg::strb_t st;
      int                 err_start;
      int                 n_wr;
      void'($urandom(60));
      test_name    = "reset";
      hit_expected = 1'b0;
      i_exp        = '0;
      d_exp        = '0;
      i_valid_i    = 1'b0;
      i_addr_i     = '0;
      d_valid_i    = 1'b0;
      d_addr_i     = '0;
      d_wdata_i    = '0;
      d_wstrb_i    = '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         mem[w[11:0]]     = fill_word(w);
         ref_mem[w[11:0]] = fill_word(w);
      end
      arst_i = 1'b1;
      repeat (5) @(posedge clk_i);
      #1;
      arst_i = 1'b0;

      test_name = "instr_fetch";
      err_start = errors;
      instr_read(14'h0400, ref_mem[12'h100]);
      // Second-level flush leaves the icache line in place
      data_req(`EXT_MEM_CTRL_ADDR, '0, 4'hF, '0);
      hit_expected = 1'b1;   // Second fetch stays in the icache
      instr_read(14'h0400, ref_mem[12'h100]);
      hit_expected = 1'b0;
      end_test(err_start);

      test_name = "data_strobe";
      err_start = errors;
      data_req(14'h0014, '0, 4'h0, ref_mem[12'h005]);
      n_wr = mem_writes;
      data_req(14'h0014, 32'hA5C3_0F96, 4'b0101, '0);
      wait (mem_writes != n_wr);
      @(posedge clk_i);
      #1;
      assert (mem[12'h005] == ref_mem[12'h005])
      else begin
         errors++;
         $display("** Error %s: memory word expected %h, actual %h", test_name,
                  ref_mem[12'h005], mem[12'h005]);
      end
      hit_expected = 1'b1;
      data_req(14'h0014, '0, 4'h0, ref_mem[12'h005]);
      hit_expected = 1'b0;
      end_test(err_start);

      test_name = "conflict";
      err_start = errors;
      for (int k = 0; k < 3; k++) begin
         data_req(14'h0040, '0, 4'h0, ref_mem[12'h010]);   // Both on first-level line 0
         data_req(14'h0080, '0, 4'h0, ref_mem[12'h020]);
      end
      end_test(err_start);

      test_name = "concurrent";
      err_start = errors;
      for (int k = 0; k < 4; k++) begin
         iw = 12'(12'h900 + k);
         dw = 12'(12'h200 + 3 * k);
         fork
            instr_read({iw, 2'b00}, ref_mem[iw]);
            data_req({dw, 2'b00}, '0, 4'h0, ref_mem[dw]);
         join
      end
      end_test(err_start);

      test_name = "invalidate";
      err_start = errors;
      data_req(14'h00C0, '0, 4'h0, ref_mem[12'h030]);
      old_w            = ref_mem[12'h030];
      mem[12'h030]     = 32'h1357_9BDF;   // Changed behind both caches
      ref_mem[12'h030] = 32'h1357_9BDF;
      instr_read(14'h20C0, ref_mem[12'h830]);   // Evicts word 0x030 from the second level
      hit_expected = 1'b1;
      data_req(14'h00C0, '0, 4'h0, old_w);
      hit_expected = 1'b0;
      data_req(`EXT_MEM_CTRL_ADDR, '0, 4'hF, '0);
      data_req(14'h00C0, '0, 4'h0, ref_mem[12'h030]);
      end_test(err_start);

      // Data words 0 to 63 and fetches from a region no data write touches
      test_name = "random_mix";
      err_start = errors;
      for (int n = 0; n < 200; n++) begin
         dw = 12'($urandom_range(0, 63));
         iw = 12'(12'h800 + $urandom_range(0, 127));
         wr = ($urandom_range(0, 1) == 1);
         st = 4'($urandom_range(1, 15));
         wd = $urandom;
         if (n % 2 == 0) begin
            fork
               instr_read({iw, 2'b00}, ref_mem[iw]);
               data_req({dw, 2'b00}, wd, wr ? st : 4'h0, ref_mem[dw]);
            join
         end else begin
            data_req({dw, 2'b00}, wd, wr ? st : 4'h0, ref_mem[dw]);
         end
      end
      end_test(err_start);

      $display("Tests %0d, errors %0d, memory reads %0d, memory writes %0d",
               tests, errors, mem_reads, mem_writes);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
ext_mem_pkg.sv
line_cache.sv
bus_merge.sv
ext_mem.sv
tb_ext_mem.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_ext_mem -o tb_ext_mem \
   && ./obj_dir/tb_ext_mem | tee /dev/stderr | grep "TB PASSED" > /dev/null \
   && { echo "Simulation result: pass"; exit 0; } \
   || { echo "Simulation result: fail"; exit 1; }
